//--- Makefile
TOP = tb_rom_bank

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rom_bank.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rom_bank.f
+incdir+verilog
verilog/rom_bank_pkg.sv
verilog/rom_bank_if.sv
verilog/rom_loader.sv
verilog/bank_mem.sv
verilog/rom_slots.sv
verilog/rom_bank_top.sv
verif/rom_bank_properties.sv
verif/tb_rom_bank.sv

//--- verif/rom_bank_properties.sv
// --------------------------------------------------
// Bank handshake assertions, bound to bank_mem
// --------------------------------------------------
`timescale 1ns/1ns

`include "rom_bank_defines.svh"

`default_nettype none

module rom_bank_properties (
    input wire clk,
    input wire reset,
    input wire wr_ack,
    input wire rd_ack,
    input wire rdy
);

    // One request served at a time
    ack_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(wr_ack && rd_ack)
    ) else $error("bank acked a read and a write in the same cycle");

    // Read data arrives a fixed number of cycles after ack
    rdy_after_ack: assert property (
        @(posedge clk) disable iff (reset) rd_ack |-> ##`BANK_LAT rdy
    ) else $error("rdy missing %0d cycles after read ack", `BANK_LAT);

    ack_before_rdy: assert property (
        @(posedge clk) disable iff (reset) rdy |-> $past(rd_ack, `BANK_LAT)
    ) else $error("rdy without a read ack %0d cycles earlier", `BANK_LAT);

    // Reset clears both ack flops
    no_ack_in_reset: assert property (
        @(posedge clk) reset |=> !(wr_ack || rd_ack)
    ) else $error("bank ack seen during reset");

endmodule

`default_nettype wire

//--- verif/tb_rom_bank.sv
// --------------------------------------------------
// Testbench for the ROM bank: download, header
// decode and gfx and snd slot reads
// --------------------------------------------------
`timescale 1ns/1ns

`include "rom_bank_defines.svh"

`default_nettype none

module tb_rom_bank;

    localparam int IMAGE_LEN      = `HEADER_LEN + 192;
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int OK_LIMIT       = 100;   // Cycles allowed for one slot read

    logic        clk;
    logic        reset;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        dwnld_busy;
    logic [7:0]  game_id;
    logic        dec_en;
    logic        dec_type;
    logic        gfx_cs;
    logic [`BANK_AW-1:0] gfx_addr;
    logic        gfx_ok;
    logic [15:0] gfx_data;
    logic        snd_cs;
    logic [`BANK_AW-1:0] snd_addr;
    logic        snd_ok;
    logic [7:0]  snd_data;

    logic [7:0]  image [IMAGE_LEN];   // Header plus data bytes
    logic [15:0] lfsr;
    int          cycles;
    int          checks;
    int          errors;

    rom_bank_top i_rom_bank_top (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .dwnld_busy  ( dwnld_busy  ),
        .game_id     ( game_id     ),
        .dec_en      ( dec_en      ),
        .dec_type    ( dec_type    ),
        .gfx_cs      ( gfx_cs      ),
        .gfx_addr    ( gfx_addr    ),
        .gfx_ok      ( gfx_ok      ),
        .gfx_data    ( gfx_data    ),
        .snd_cs      ( snd_cs      ),
        .snd_addr    ( snd_addr    ),
        .snd_ok      ( snd_ok      ),
        .snd_data    ( snd_data    )
    );

    bind bank_mem rom_bank_properties i_rom_bank_properties (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .wr_ack ( wr.ack ),
        .rd_ack ( rd.ack ),
        .rdy    ( rd.rdy )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Word w of the data area, first byte of the pair high
    function automatic logic [15:0] expected_word(input int w);
        return {image[`HEADER_LEN + 2*w], image[`HEADER_LEN + 2*w + 1]};
    endfunction

    function automatic logic [7:0] expected_snd(input int a);
        logic [15:0] w;
        w = expected_word(`SND_OFFSET + a / 2);
        return (a % 2) ? w[7:0] : w[15:8];
    endfunction

    task automatic fill_image();
        logic [7:0] byte_v;
        for (int i = 0; i < IMAGE_LEN; i++) begin
            byte_v = '0;
            for (int b = 0; b < 8; b++) begin
                lfsr   = lfsr_step(lfsr);
                byte_v = {byte_v[6:0], lfsr[0]};
            end
            image[i] = byte_v;
        end
    endtask

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic fail_msg(input string text);
        checks++;
        errors++;
        $display("%s", text);
    endtask

    // Returns at the falling edge where ok is first seen
    task automatic wait_ok(input logic snd, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < OK_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = snd ? snd_ok : gfx_ok;
        end
    endtask

    task automatic read_gfx(input int a);
        logic seen;
        gfx_cs   = 1'b1;
        gfx_addr = `BANK_AW'(a);
        wait_ok(1'b0, seen);
        if (!seen) fail_msg($sformatf("gfx read of word %0d never got ok", a));
        else compare("gfx_data", gfx_data, expected_word(a));
    endtask

    task automatic read_snd(input int a);
        logic seen;
        snd_cs   = 1'b1;
        snd_addr = `BANK_AW'(a);
        wait_ok(1'b1, seen);
        if (!seen) fail_msg($sformatf("snd read of byte %0d never got ok", a));
        else compare("snd_data", 16'(snd_data), 16'(expected_snd(a)));
    endtask

    task automatic test_reset_state();
        gfx_cs = 1'b1;   // No slot holds valid data yet
        snd_cs = 1'b1;
        @(negedge clk);
        compare("gfx_ok", 16'(gfx_ok), 16'h0);
        compare("snd_ok", 16'(snd_ok), 16'h0);
        compare("dwnld_busy", 16'(dwnld_busy), 16'h0);
        gfx_cs = 1'b0;
        snd_cs = 1'b0;
    endtask

    task automatic test_download();
        int n;
        downloading = 1'b1;
        for (int i = 0; i < IMAGE_LEN; i++) begin
            @(negedge clk);
            ioctl_addr = 25'(i);
            ioctl_data = image[i];
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            repeat (8) @(negedge clk);   // Room for the bank write
        end
        downloading = 1'b0;
        n = 0;
        while (dwnld_busy && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (dwnld_busy) fail_msg("dwnld_busy stayed high after the download ended");
        compare("game_id", 16'(game_id), 16'(image[`HDR_GAME]));
        compare("dec_en", 16'(dec_en), 16'(|image[`HDR_FLAGS][1:0]));
        compare("dec_type", 16'(dec_type), 16'(image[`HDR_FLAGS][1]));
    endtask

    task automatic test_gfx_reads();
        int addrs [7] = '{0, 1, 2, 17, 40, 63, 80};
        foreach (addrs[i]) read_gfx(addrs[i]);
        gfx_cs = 1'b0;
    endtask

    task automatic test_snd_reads();
        int addrs [8] = '{0, 1, 4, 5, 7, 30, 62, 63};
        foreach (addrs[i]) read_snd(addrs[i]);
        snd_cs = 1'b0;
    endtask

    task automatic test_hold_and_change();
        read_gfx(20);
        repeat (5) begin
            @(negedge clk);
            if (!gfx_ok) fail_msg("gfx_ok dropped while cs and address were held");
            compare("gfx_data", gfx_data, expected_word(20));
        end
        gfx_addr = `BANK_AW'(21);   // Word not in the slot
        @(negedge clk);
        if (gfx_ok) fail_msg("gfx_ok stayed high after the address changed");
        read_gfx(21);
        gfx_cs = 1'b0;
    endtask

    task automatic test_both_slots();
        int n;
        gfx_cs   = 1'b1;
        gfx_addr = `BANK_AW'(33);
        snd_cs   = 1'b1;
        snd_addr = `BANK_AW'(41);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(gfx_ok && snd_ok) && n < OK_LIMIT);
        if (!(gfx_ok && snd_ok)) begin
            fail_msg("gfx and snd slots did not both finish");
        end else begin
            compare("gfx_data", gfx_data, expected_word(33));
            compare("snd_data", 16'(snd_data), 16'(expected_snd(41)));
        end
        gfx_cs = 1'b0;
        snd_cs = 1'b0;
    endtask

    // Ends the run if the tests stall
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        checks      = 0;
        errors      = 0;
        lfsr        = 16'd75;
        fill_image();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset_state();
        test_download();
        test_gfx_reads();
        test_snd_reads();
        test_hold_and_change();
        test_both_slots();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bank_mem.sv
// --------------------------------------------------
// On-chip bank model with write priority and a fixed
// read latency
// --------------------------------------------------
`timescale 1ns/1ns

`include "rom_bank_defines.svh"

`default_nettype none

module bank_mem (
    input wire        clk,
    input wire        reset,
    bank_wr_if.wr_dst wr,
    bank_rd_if.rd_dst rd
);

    rom_bank_pkg::bank_word_t  mem [2**`BANK_AW];
    rom_bank_pkg::bank_addr_t  rd_addr_q;
    rom_bank_pkg::bank_rdata_u dpipe [`BANK_LAT];
    logic [`BANK_LAT-1:0]      vpipe;     // Ack delayed towards rdy
    logic                      busy;      // Read in flight
    logic                      idle;
    logic                      take_wr;
    logic                      take_rd;

    // No new request while a write is being acked or a read is out
    assign idle    = !busy && !wr.ack;
    assign take_wr = idle && wr.we;
    assign take_rd = idle && !wr.we && rd.rd;  // Writes win

    assign rd.rdy  = vpipe[`BANK_LAT-1];
    assign rd.data = dpipe[`BANK_LAT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr.ack <= 1'b0;
            rd.ack <= 1'b0;
            busy   <= 1'b0;
            vpipe  <= '0;
        end else begin
            wr.ack <= take_wr;
            rd.ack <= take_rd;
            vpipe  <= {vpipe[`BANK_LAT-2:0], rd.ack};
            if (take_rd) begin
                busy <= 1'b1;
            end else if (rd.rdy) begin
                busy <= 1'b0;
            end
        end
    end

    // Array access and the read data delay line
    always_ff @(posedge clk) begin
        if (take_wr) begin
            mem[wr.addr] <= wr.data;
        end
        if (take_rd) begin
            rd_addr_q <= rd.addr;
        end
        dpipe[0].word <= mem[rd_addr_q];
        for (int i = 1; i < `BANK_LAT; i++) begin
            dpipe[i] <= dpipe[i-1];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rom_bank_defines.svh
// --------------------------------------------------
// Bank geometry, read latency and download layout
// --------------------------------------------------
`ifndef ROM_BANK_DEFINES_SVH
`define ROM_BANK_DEFINES_SVH

`default_nettype none

// Word address width of the bank
`define BANK_AW     12

// Cycles from read ack to rdy
`define BANK_LAT    3

// Download header length in bytes
`define HEADER_LEN  32

// Header byte offsets
`define HDR_FLAGS   16
`define HDR_GAME    24

// Sound region start, in words
`define SND_OFFSET  64

`default_nettype wire

`endif

//--- verilog/rom_bank_if.sv
// --------------------------------------------------
// Bank write and bank read interfaces
// --------------------------------------------------
`timescale 1ns/1ns

`default_nettype none

// Loader to bank, we held until the ack pulse
interface bank_wr_if;
    rom_bank_pkg::bank_addr_t addr;
    rom_bank_pkg::bank_word_t data;
    logic                     we;
    logic                     ack;

    modport wr_src (output addr, output data, output we, input ack);
    modport wr_dst (input addr, input data, input we, output ack);
endinterface

// Slots to bank, rd held until ack and data valid with rdy
interface bank_rd_if;
    rom_bank_pkg::bank_addr_t  addr;
    logic                      rd;
    logic                      ack;
    logic                      rdy;
    rom_bank_pkg::bank_rdata_u data;

    modport rd_src (output addr, output rd, input ack, input rdy, input data);
    modport rd_dst (input addr, input rd, output ack, output rdy, output data);
endinterface

`default_nettype wire

//--- verilog/rom_bank_pkg.sv
// --------------------------------------------------
// Shared bank address, data and read word types
// --------------------------------------------------
`include "rom_bank_defines.svh"

`default_nettype none

package rom_bank_pkg;

    // Word address into the bank
    typedef logic [`BANK_AW-1:0] bank_addr_t;

    // Bank data word
    typedef logic [15:0] bank_word_t;

    // Download and snd slot byte
    typedef logic [7:0] rom_byte_t;

    // Byte view of a bank word, first downloaded byte high
    typedef struct packed {
        rom_byte_t hi;
        rom_byte_t lo;
    } bank_bytes_t;

    // Read word seen either whole or as two bytes
    typedef union packed {
        bank_word_t  word;
        bank_bytes_t bytes;
    } bank_rdata_u;

endpackage

`default_nettype wire

//--- verilog/rom_bank_top.sv
// --------------------------------------------------
// ROM bank top: loader, bank model and read slots
// --------------------------------------------------
`timescale 1ns/1ns

`include "rom_bank_defines.svh"

`default_nettype none

module rom_bank_top (
    input  wire                             clk,
    input  wire                             reset,
    // Download stream
    input  wire                             downloading,
    input  wire  [24:0]                     ioctl_addr,
    input  wire  rom_bank_pkg::rom_byte_t   ioctl_data,
    input  wire                             ioctl_wr,
    output logic                            dwnld_busy,
    output rom_bank_pkg::rom_byte_t         game_id,
    output logic                            dec_en,
    output logic                            dec_type,
    // gfx slot
    input  wire                             gfx_cs,
    input  wire  rom_bank_pkg::bank_addr_t  gfx_addr,
    output logic                            gfx_ok,
    output rom_bank_pkg::bank_word_t        gfx_data,
    // snd slot
    input  wire                             snd_cs,
    input  wire  [`BANK_AW-1:0]             snd_addr,
    output logic                            snd_ok,
    output rom_bank_pkg::rom_byte_t         snd_data
);

    bank_wr_if i_wr_if ();
    bank_rd_if i_rd_if ();

    rom_loader i_rom_loader (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .dwnld_busy  ( dwnld_busy  ),
        .game_id     ( game_id     ),
        .dec_en      ( dec_en      ),
        .dec_type    ( dec_type    ),
        .wr          ( i_wr_if     )
    );

    bank_mem i_bank_mem (
        .clk   ( clk     ),
        .reset ( reset   ),
        .wr    ( i_wr_if ),
        .rd    ( i_rd_if )
    );

    rom_slots i_rom_slots (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .gfx_cs      ( gfx_cs      ),
        .gfx_addr    ( gfx_addr    ),
        .gfx_ok      ( gfx_ok      ),
        .gfx_data    ( gfx_data    ),
        .snd_cs      ( snd_cs      ),
        .snd_addr    ( snd_addr    ),
        .snd_ok      ( snd_ok      ),
        .snd_data    ( snd_data    ),
        .rd          ( i_rd_if     )
    );

endmodule

`default_nettype wire

//--- verilog/rom_loader.sv
// --------------------------------------------------
// Download loader: header decode, byte pairing and
// bank write requests
// --------------------------------------------------
`timescale 1ns/1ns

`include "rom_bank_defines.svh"

`default_nettype none

module rom_loader (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            downloading,
    input  wire  [24:0]                    ioctl_addr,
    input  wire  rom_bank_pkg::rom_byte_t  ioctl_data,
    input  wire                            ioctl_wr,
    output logic                           dwnld_busy,
    output rom_bank_pkg::rom_byte_t        game_id,
    output logic                           dec_en,
    output logic                           dec_type,
    bank_wr_if.wr_src                      wr
);

    logic                    header;     // Address still inside the header
    logic [24:0]             data_addr;  // Byte address past the header
    logic                    hdr_wr;
    logic                    data_wr;
    rom_bank_pkg::rom_byte_t hi_byte;    // Even byte waiting for its pair

    assign header    = ioctl_addr < 25'(`HEADER_LEN);
    assign data_addr = ioctl_addr - 25'(`HEADER_LEN);
    assign hdr_wr    = downloading && ioctl_wr && header;
    assign data_wr   = downloading && ioctl_wr && !header;

    // Busy until the last word has reached the bank
    assign dwnld_busy = downloading || wr.we;

    // Header fields
    always_ff @(posedge clk) begin
        if (reset) begin
            game_id  <= '0;
            dec_en   <= 1'b0;
            dec_type <= 1'b0;
        end else if (hdr_wr) begin
            if (ioctl_addr == 25'(`HDR_GAME)) begin
                game_id <= ioctl_data;
            end
            if (ioctl_addr == 25'(`HDR_FLAGS)) begin
                dec_en   <= |ioctl_data[1:0];  // Either decoder type
                dec_type <= ioctl_data[1];
            end
        end
    end

    // Write request, held until the bank answers
    always_ff @(posedge clk) begin
        if (reset) begin
            wr.we <= 1'b0;
        end else if (data_wr && data_addr[0]) begin
            wr.we <= 1'b1;
        end else if (wr.ack) begin
            wr.we <= 1'b0;
        end
    end

    // Pairing of download bytes into words
    always_ff @(posedge clk) begin
        if (data_wr) begin
            if (!data_addr[0]) begin
                hi_byte <= ioctl_data;  // First byte goes high
            end else begin
                wr.addr <= data_addr[`BANK_AW:1];
                wr.data <= {hi_byte, ioctl_data};
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rom_slots.sv
// --------------------------------------------------
// Cached gfx and snd read slots sharing one bank
// --------------------------------------------------
`timescale 1ns/1ns

`include "rom_bank_defines.svh"

`default_nettype none

module rom_slots (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             downloading,
    // gfx slot, 16-bit words
    input  wire                             gfx_cs,
    input  wire  rom_bank_pkg::bank_addr_t  gfx_addr,
    output logic                            gfx_ok,
    output rom_bank_pkg::bank_word_t        gfx_data,
    // snd slot, byte address into the sound region
    input  wire                             snd_cs,
    input  wire  [`BANK_AW-1:0]             snd_addr,
    output logic                            snd_ok,
    output rom_bank_pkg::rom_byte_t         snd_data,
    bank_rd_if.rd_src                       rd
);

    localparam rom_bank_pkg::bank_addr_t SND_BASE = `BANK_AW'(`SND_OFFSET);

    rom_bank_pkg::bank_addr_t  snd_waddr;
    rom_bank_pkg::bank_addr_t  gfx_tag;
    rom_bank_pkg::bank_addr_t  snd_tag;
    rom_bank_pkg::bank_rdata_u gfx_q;
    rom_bank_pkg::bank_rdata_u snd_q;
    logic                      gfx_valid;
    logic                      snd_valid;
    logic                      gfx_hit;
    logic                      snd_hit;
    logic                      gfx_miss;
    logic                      snd_miss;
    logic                      busy;    // Request out until rdy
    logic                      owner;   // 1 when snd owns the bank
    logic                      prio;    // Winner on a tie, 1 for snd
    logic                      pick;

    // Sound words start at the region offset
    assign snd_waddr = SND_BASE + {1'b0, snd_addr[`BANK_AW-1:1]};

    assign gfx_hit  = gfx_valid && (gfx_tag == gfx_addr);
    assign snd_hit  = snd_valid && (snd_tag == snd_waddr);
    assign gfx_miss = gfx_cs && !gfx_hit;
    assign snd_miss = snd_cs && !snd_hit;
    assign pick     = (gfx_miss && snd_miss) ? prio : snd_miss;

    assign gfx_ok   = gfx_cs && gfx_hit;
    assign snd_ok   = snd_cs && snd_hit;
    assign gfx_data = gfx_q.word;
    assign snd_data = snd_addr[0] ? snd_q.bytes.lo : snd_q.bytes.hi;  // Even byte is high

    // Arbitration and request handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            rd.rd     <= 1'b0;
            busy      <= 1'b0;
            owner     <= 1'b0;
            prio      <= 1'b0;
            gfx_valid <= 1'b0;
            snd_valid <= 1'b0;
        end else begin
            if (!busy && !downloading && (gfx_miss || snd_miss)) begin
                rd.rd <= 1'b1;
                busy  <= 1'b1;
                owner <= pick;
                prio  <= !pick;  // Other slot wins the next tie
            end
            if (rd.ack) begin
                rd.rd <= 1'b0;
            end
            if (busy && rd.rdy) begin
                busy <= 1'b0;
                if (owner) begin
                    snd_valid <= 1'b1;
                end else begin
                    gfx_valid <= 1'b1;
                end
            end
            // Bank contents change during a download
            if (downloading) begin
                gfx_valid <= 1'b0;
                snd_valid <= 1'b0;
            end
        end
    end

    // Request address and cached words
    always_ff @(posedge clk) begin
        if (!busy && !downloading && (gfx_miss || snd_miss)) begin
            rd.addr <= pick ? snd_waddr : gfx_addr;
        end
        if (busy && rd.rdy) begin
            if (owner) begin
                snd_tag <= rd.addr;
                snd_q   <= rd.data;
            end else begin
                gfx_tag <= rd.addr;
                gfx_q   <= rd.data;
            end
        end
    end

endmodule

`default_nettype wire
